/* design/game_pkg.sv */
// Game-side piece kinds and field widths carried over the link
package game_pkg;

    // Garbage line count width
    localparam int GBG_BITS = 4;

    // Piece kinds
    typedef enum logic [3:0] {
        TILE_NONE    = 4'd0,  // No piece
        TILE_I       = 4'd1,
        TILE_O       = 4'd2,
        TILE_T       = 4'd3,
        TILE_S       = 4'd4,
        TILE_Z       = 4'd5,
        TILE_J       = 4'd6,
        TILE_L       = 4'd7,
        TILE_GARBAGE = 4'd8
    } tile_type_t;

endpackage : game_pkg

/* design/network_pkg.sv */
// Link framing sizes, frame kinds, session states and the shared payload word
package network_pkg;

    // ********************
    // Framing
    // ********************
    localparam int LANES        = 4;   // Data lanes beside the header lane
    localparam int FRAME_BEATS  = 5;   // Control beat then four nibbles
    localparam int PAYLOAD_BITS = 16;
    localparam int RETRY_CYCLES = 64;  // Cycles without ack before a resend

    // Session states
    localparam int                   SESS_BITS       = 2;
    localparam logic [SESS_BITS-1:0] SESS_IDLE       = 2'd0;
    localparam logic [SESS_BITS-1:0] SESS_READY_SENT = 2'd1;
    localparam logic [SESS_BITS-1:0] SESS_ACTIVE     = 2'd2;
    localparam logic [SESS_BITS-1:0] SESS_OVER       = 2'd3;

    typedef enum logic [1:0] {
        KIND_DATA = 2'd0,
        KIND_CTRL = 2'd1,
        KIND_ACK  = 2'd2
    } frame_kind_t;

    // ********************
    // Payload word
    // ********************
    typedef union packed {
        struct packed {
            logic [game_pkg::GBG_BITS-1:0] garbage;
            game_pkg::tile_type_t          hold;
            game_pkg::tile_type_t          next_piece;
            logic [3:0]                    lines_cleared;
        } upd;   // KIND_DATA
        struct packed {
            logic                    ready;
            logic                    lost;
            logic                    ack_seq;
            logic [PAYLOAD_BITS-4:0] spare;  // Always zero on the wire
        } ctrl;  // KIND_CTRL and KIND_ACK
    } link_payload_u;

endpackage : network_pkg

/* design/session_fsm.sv */
// Player session FSM owning the sequence bit, the outstanding reliable frame and its retry timer
`timescale 1ns/100ps

module session_fsm (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          player_ready,
    input  logic                          top_out,
    input  logic                          update_data,
    input  logic [game_pkg::GBG_BITS-1:0] garbage,
    input  game_pkg::tile_type_t          hold,
    input  game_pkg::tile_type_t          next_piece,
    input  logic [3:0]                    lines_cleared,
    input  logic                          ack_received,
    input  logic                          ack_seq_in,
    input  logic                          peer_ctrl,
    input  logic                          peer_ready,
    input  logic                          peer_lost,
    output logic                          rel_req,
    output logic                          rel_send,
    output network_pkg::frame_kind_t      rel_kind,
    output logic                          rel_seq,
    output network_pkg::link_payload_u    rel_payload,
    output logic                          game_active,
    output logic                          game_lost,
    output logic                          opponent_ready,
    output logic                          opponent_lost
);
    import network_pkg::*;

    logic [SESS_BITS-1:0]            state;
    logic [$clog2(RETRY_CYCLES)-1:0] retry_cnt;
    logic                            ready_d;
    logic                            ready_acked;
    logic                            lost_pend;   // Lost frame waiting for a free slot
    logic                            ready_rise;
    logic                            lost_evt;
    logic                            ack_ok;
    logic                            post;
    frame_kind_t                     post_kind;
    link_payload_u                   post_pl;

    assign ready_rise  = player_ready && !ready_d;
    assign lost_evt    = lost_pend || (state == SESS_ACTIVE && top_out);
    assign ack_ok      = ack_received && rel_req && (ack_seq_in == rel_seq);
    assign game_active = (state == SESS_ACTIVE);

    // ********************
    // Frame to post
    // ********************
    always_comb begin
        post      = 1'b0;
        post_kind = KIND_CTRL;
        post_pl   = '0;
        if (!rel_req) begin
            if (lost_evt) begin
                post               = 1'b1;
                post_pl.ctrl.ready = 1'b1;
                post_pl.ctrl.lost  = 1'b1;
            end else if (state == SESS_IDLE && ready_rise) begin
                post               = 1'b1;
                post_pl.ctrl.ready = 1'b1;
            end else if (state == SESS_ACTIVE && update_data) begin
                post                      = 1'b1;
                post_kind                 = KIND_DATA;
                post_pl.upd.garbage       = garbage;
                post_pl.upd.hold          = hold;
                post_pl.upd.next_piece    = next_piece;
                post_pl.upd.lines_cleared = lines_cleared;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (post) begin
            rel_kind    <= post_kind;
            rel_payload <= post_pl;
        end
    end

    // ********************
    // Session and retry
    // ********************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= SESS_IDLE;
            retry_cnt      <= '0;
            ready_d        <= 1'b0;
            ready_acked    <= 1'b0;
            lost_pend      <= 1'b0;
            rel_req        <= 1'b0;
            rel_send       <= 1'b0;
            rel_seq        <= 1'b0;
            game_lost      <= 1'b0;
            opponent_ready <= 1'b0;
            opponent_lost  <= 1'b0;
        end else begin
            ready_d   <= player_ready;
            rel_send  <= 1'b0;
            lost_pend <= lost_evt && rel_req;

            if (post) begin
                rel_req   <= 1'b1;
                rel_send  <= 1'b1;
                retry_cnt <= '0;
            end else if (ack_ok) begin
                rel_req <= 1'b0;
                rel_seq <= !rel_seq;  // Next frame gets the other bit
            end else if (rel_req) begin
                if (retry_cnt == RETRY_CYCLES-1) begin
                    rel_send  <= 1'b1;
                    retry_cnt <= '0;
                end else begin
                    retry_cnt <= retry_cnt + 1'b1;
                end
            end

            if (peer_ctrl && peer_ready)
                opponent_ready <= 1'b1;
            if (peer_ctrl && peer_lost)
                opponent_lost <= 1'b1;
            if (ack_ok && state == SESS_READY_SENT)
                ready_acked <= 1'b1;

            case (state)
                SESS_IDLE: begin
                    if (ready_rise)
                        state <= SESS_READY_SENT;
                end
                SESS_READY_SENT: begin
                    if (opponent_lost)
                        state <= SESS_OVER;
                    else if (ready_acked && opponent_ready)
                        state <= SESS_ACTIVE;
                end
                SESS_ACTIVE: begin
                    if (top_out) begin
                        state     <= SESS_OVER;
                        game_lost <= 1'b1;
                    end else if (opponent_lost) begin
                        state <= SESS_OVER;
                    end
                end
                default: state <= SESS_OVER;  // Held until reset
            endcase
        end
    end

endmodule : session_fsm

/* design/packet_arbiter.sv */
// Fixed-priority sharing of the serializer between acknowledgements and reliable frames
`timescale 1ns/100ps

module packet_arbiter (
    input  logic                       ack_req,
    input  logic                       ack_seq,
    input  logic                       rel_req,
    input  logic                       rel_send,
    input  network_pkg::frame_kind_t   rel_kind,
    input  logic                       rel_seq,
    input  network_pkg::link_payload_u rel_payload,
    input  logic                       busy,
    output logic                       ack_grant,
    output logic                       load,
    output network_pkg::frame_kind_t   load_kind,
    output logic                       load_seq,
    output network_pkg::link_payload_u load_payload
);
    import network_pkg::*;

    // Acknowledgement always wins
    assign ack_grant = ack_req && !busy;
    assign load      = ack_grant || (rel_req && rel_send && !busy && !ack_req);

    always_comb begin
        load_kind    = rel_kind;
        load_seq     = rel_seq;
        load_payload = rel_payload;
        if (ack_req) begin
            load_kind                 = KIND_ACK;
            load_seq                  = ack_seq;
            load_payload              = '0;
            load_payload.ctrl.ack_seq = ack_seq;
        end
    end

endmodule : packet_arbiter

/* design/lane_serializer.sv */
// Frame transmitter driving the header lane and the four data lanes
`timescale 1ns/100ps

module lane_serializer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          load,
    input  network_pkg::frame_kind_t      load_kind,
    input  logic                          load_seq,
    input  network_pkg::link_payload_u    load_payload,
    output logic                          busy,
    output logic                          serial_out_h,
    output logic [network_pkg::LANES-1:0] serial_out
);
    import network_pkg::*;

    logic [$clog2(FRAME_BEATS+2)-1:0] beat;
    logic [PAYLOAD_BITS-1:0]          shift;

    // Payload nibbles leave MSB first
    always_ff @(posedge clk) begin
        if (load && !busy)
            shift <= load_payload;
        else if (busy)
            shift <= shift << LANES;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy         <= 1'b0;
            beat         <= '0;
            serial_out_h <= 1'b0;
            serial_out   <= '0;
        end else if (!busy) begin
            if (load) begin
                busy         <= 1'b1;
                beat         <= 1'b1;
                serial_out_h <= 1'b1;
                serial_out   <= {1'b0, load_seq, load_kind};  // Control beat
            end
        end else if (beat < FRAME_BEATS) begin
            serial_out <= shift[PAYLOAD_BITS-1 -: LANES];
            beat       <= beat + 1'b1;
        end else if (beat == FRAME_BEATS) begin
            serial_out_h <= 1'b0;  // Guard idle cycle
            serial_out   <= '0;
            beat         <= beat + 1'b1;
        end else begin
            busy <= 1'b0;
            beat <= '0;
        end
    end

endmodule : lane_serializer

/* design/lane_deserializer.sv */
// Frame receiver that rebuilds peer frames, drops duplicates and raises acknowledgement requests
`timescale 1ns/100ps

module lane_deserializer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          serial_in_h,
    input  logic [network_pkg::LANES-1:0] serial_in,
    input  logic                          ack_grant,
    output logic                          ack_req,
    output logic                          ack_seq,
    output logic                          ack_received,
    output logic                          ack_seq_in,
    output logic                          peer_ctrl,
    output logic                          peer_ready,
    output logic                          peer_lost,
    output logic                          peer_update,
    output logic [game_pkg::GBG_BITS-1:0] opponent_garbage,
    output game_pkg::tile_type_t          opponent_hold
);
    import game_pkg::*;
    import network_pkg::*;

    logic [$clog2(FRAME_BEATS)-1:0] beat;
    frame_kind_t                    rx_kind;
    logic                           rx_seq;
    logic [PAYLOAD_BITS-1:0]        rx_word;
    link_payload_u                  rx_view;
    logic                           expect_seq;
    logic                           last_beat;

    assign rx_view   = rx_word;
    assign last_beat = serial_in_h && (beat == FRAME_BEATS-1);

    // Valid alongside the pulses
    assign ack_seq_in = rx_view.ctrl.ack_seq;
    assign peer_ready = rx_view.ctrl.ready;
    assign peer_lost  = rx_view.ctrl.lost;

    always_ff @(posedge clk) begin
        if (serial_in_h && beat == '0) begin
            rx_kind <= frame_kind_t'(serial_in[1:0]);
            rx_seq  <= serial_in[2];
        end else if (serial_in_h) begin
            rx_word <= {rx_word[PAYLOAD_BITS-LANES-1:0], serial_in};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat             <= '0;
            expect_seq       <= 1'b0;
            ack_req          <= 1'b0;
            ack_seq          <= 1'b0;
            ack_received     <= 1'b0;
            peer_ctrl        <= 1'b0;
            peer_update      <= 1'b0;
            opponent_garbage <= '0;
            opponent_hold    <= TILE_NONE;
        end else begin
            ack_received <= 1'b0;
            peer_ctrl    <= 1'b0;
            peer_update  <= 1'b0;

            if (!serial_in_h || last_beat)
                beat <= '0;
            else
                beat <= beat + 1'b1;

            if (peer_update) begin
                opponent_garbage <= rx_view.upd.garbage;
                opponent_hold    <= rx_view.upd.hold;
            end

            if (ack_grant)
                ack_req <= 1'b0;

            if (last_beat && rx_kind == KIND_ACK) begin
                ack_received <= 1'b1;
            end else if (last_beat && (rx_kind == KIND_DATA || rx_kind == KIND_CTRL)) begin
                ack_req <= 1'b1;  // Duplicates are acked too
                ack_seq <= rx_seq;
                if (rx_seq == expect_seq) begin
                    expect_seq  <= !expect_seq;
                    peer_ctrl   <= (rx_kind == KIND_CTRL);
                    peer_update <= (rx_kind == KIND_DATA);
                end
            end
        end
    end

endmodule : lane_deserializer

/* design/link_top.sv */
// Board link top level joining session control, arbitration and the serial lanes
`timescale 1ns/100ps

module link_top (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             player_ready,
    input  logic                             top_out,
    input  logic                             update_data,
    input  logic [game_pkg::GBG_BITS-1:0]    garbage,
    input  game_pkg::tile_type_t             hold,
    input  game_pkg::tile_type_t             next_piece,
    input  logic [3:0]                       lines_cleared,
    input  logic                             serial_in_h,
    input  logic [network_pkg::LANES-1:0]    serial_in,
    output logic                             serial_out_h,
    output logic [network_pkg::LANES-1:0]    serial_out,
    output logic                             game_active,
    output logic                             game_lost,
    output logic                             opponent_ready,
    output logic                             opponent_lost,
    output logic [game_pkg::GBG_BITS-1:0]    opponent_garbage,
    output game_pkg::tile_type_t             opponent_hold
);
    import network_pkg::*;

    // Reliable frame source
    logic          rel_req, rel_send, rel_seq;
    frame_kind_t   rel_kind;
    link_payload_u rel_payload;

    // Acknowledgement source and receive pulses
    logic ack_req, ack_seq, ack_grant;
    logic ack_received, ack_seq_in;
    logic peer_ctrl, peer_ready, peer_lost;

    // Serializer side
    logic          load, load_seq, busy;
    frame_kind_t   load_kind;
    link_payload_u load_payload;

    session_fsm session_inst (.*);

    packet_arbiter arbiter_inst (.*);

    lane_serializer tx_inst (.*);

    // Update pulse not needed at this level
    lane_deserializer rx_inst (
        .peer_update(),
        .*
    );

endmodule : link_top

/* verification/link_assert.sv */
// Bound checks on the transmit framing and the serializer sharing rules
`timescale 1ns/100ps

module link_assert (
    input logic clk,
    input logic arst_n,
    input logic serial_in_h,
    input logic serial_out_h,
    input logic load,
    input logic busy,
    input logic ack_req,
    input logic ack_grant
);
    import network_pkg::*;

    // Header lane spans exactly one frame
    header_len: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(serial_out_h) |-> serial_out_h [*FRAME_BEATS] ##1 !serial_out_h)
        else $error("header lane high for other than FRAME_BEATS cycles");

    // Busy covers the frame and its guard cycle, with no load inside
    load_idle: assert property (@(posedge clk) disable iff (!arst_n)
        load |=> (!load throughout busy [*FRAME_BEATS+1]))
        else $error("load while serializer busy");

    // A grant consumes the request unless a new peer frame ends alongside
    grant_req: assert property (@(posedge clk) disable iff (!arst_n)
        ack_grant && !serial_in_h |=> !ack_req)
        else $error("ack request still pending after its grant");

    // Guard cycle after the header falls
    frame_gap: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(serial_out_h) |=> !serial_out_h)
        else $error("frames adjacent without idle cycle");

endmodule : link_assert

// Serializer and arbiter nets inside the top level
bind link_top link_assert link_checks (
    .clk          (clk),
    .arst_n       (arst_n),
    .serial_in_h  (serial_in_h),
    .serial_out_h (serial_out_h),
    .load         (load),
    .busy         (busy),
    .ack_req      (ack_req),
    .ack_grant    (ack_grant)
);

/* verification/link_tb.sv */
// Testbench for the board link driving a peer model from a stimulus table
`timescale 1ns/100ps

module link_tb;
    import game_pkg::*;
    import network_pkg::*;

    localparam logic [2:0] ACT_SET    = 3'd0;
    localparam logic [2:0] ACT_INJECT = 3'd1;
    localparam logic [2:0] ACT_WAIT   = 3'd2;
    localparam logic [2:0] ACT_QUIET  = 3'd3;
    localparam logic [2:0] ACT_RESET  = 3'd4;

    typedef struct packed {
        logic [2:0]  act;
        logic [1:0]  kind;     // Frame to inject or expected frame
        logic        seq;
        logic [15:0] payload;  // Also the update fields for ACT_SET
        logic [7:0]  count;
        logic        retry;
        logic [2:0]  drive;    // player_ready, update_data, top_out
        logic        chk;
        logic [3:0]  lvl;      // game_active, game_lost, opponent_ready, opponent_lost
        logic [7:0]  opp;      // opponent_garbage, opponent_hold
    } row_t;

    logic                 clk;
    logic                 arst_n;
    logic                 player_ready;
    logic                 top_out;
    logic                 update_data;
    logic [GBG_BITS-1:0]  garbage;
    tile_type_t           hold;
    tile_type_t           next_piece;
    logic [3:0]           lines_cleared;
    logic                 serial_in_h;
    logic [LANES-1:0]     serial_in;
    logic                 serial_out_h;
    logic [LANES-1:0]     serial_out;
    logic                 game_active;
    logic                 game_lost;
    logic                 opponent_ready;
    logic                 opponent_lost;
    logic [GBG_BITS-1:0]  opponent_garbage;
    tile_type_t           opponent_hold;

    row_t        rows[$];
    logic [31:0] lfsr_state = 32'h5464;
    int          cycles = 0;
    int          cycle_limit = 0;

    link_top dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit)
            fail_run("Timeout: cycle limit reached before the table finished");
    end

    // ********************
    // Helpers
    // ********************
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        if (got !== expected)
            fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [3:0] rand_bits(input int n);
        logic [3:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = {val[2:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Garbage, hold, next piece, lines cleared
    function automatic logic [15:0] rand_update();
        logic [3:0] g;
        logic [3:0] h;
        logic [3:0] n;
        logic [3:0] l;
        g = rand_bits(4);
        h = rand_bits(3);
        n = rand_bits(3);
        l = rand_bits(2);
        return {g, h, n, l};
    endfunction

    function automatic logic [15:0] ctrl_word(input logic ready, input logic lost,
                                              input logic ack);
        return {ready, lost, ack, 13'd0};
    endfunction

    function automatic void add_row(input logic [2:0] act, input logic [1:0] kind,
                                    input logic seq, input logic [15:0] payload,
                                    input logic [7:0] count, input logic retry,
                                    input logic [2:0] drive, input logic chk,
                                    input logic [3:0] lvl, input logic [7:0] opp);
        rows.push_back({act, kind, seq, payload, count, retry, drive, chk, lvl, opp});
    endfunction

    task automatic apply_reset();
        arst_n        = 1'b0;
        player_ready  = 1'b0;
        top_out       = 1'b0;
        update_data   = 1'b0;
        garbage       = '0;
        hold          = TILE_NONE;
        next_piece    = TILE_NONE;
        lines_cleared = '0;
        serial_in_h   = 1'b0;
        serial_in     = '0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    // update_data and top_out last one cycle
    task automatic apply_inputs(input row_t r);
        @(posedge clk);
        #2;
        player_ready  = r.drive[2];
        update_data   = r.drive[1];
        top_out       = r.drive[0];
        garbage       = r.payload[15:12];
        hold          = tile_type_t'(r.payload[11:8]);
        next_piece    = tile_type_t'(r.payload[7:4]);
        lines_cleared = r.payload[3:0];
        @(posedge clk);
        #2;
        update_data = 1'b0;
        top_out     = 1'b0;
    endtask

    // Peer model on the wire format
    task automatic inject_frame(input logic [1:0] kind, input logic seq,
                                input logic [15:0] payload);
        @(posedge clk);
        #2;
        serial_in_h = 1'b1;
        serial_in   = {1'b0, seq, kind};
        for (int i = 3; i >= 0; i--) begin
            @(posedge clk);
            #2;
            serial_in = payload[i*4 +: 4];
        end
        @(posedge clk);
        #2;
        serial_in_h = 1'b0;
        serial_in   = '0;
    endtask

    task automatic capture_frame(input int max_cycles, output logic [1:0] kind,
                                 output logic seq, output logic [15:0] payload);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!serial_out_h) begin
            waited++;
            if (waited > max_cycles)
                fail_run($sformatf("No outgoing frame within %0d cycles", max_cycles));
            @(negedge clk);
        end
        kind = serial_out[1:0];
        seq  = serial_out[2];
        check_val("serial_out[3] in control beat", serial_out[3], 1'b0);
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            payload = {payload[11:0], serial_out};
        end
    endtask

    task automatic build_table();
        logic [15:0] upd1;
        logic [15:0] upd2;
        logic [15:0] peer;
        upd1 = rand_update();
        upd2 = rand_update();
        peer = rand_update();
        add_row(ACT_QUIET,  0,         0, 0,                  20, 0, 3'b000, 1, 4'b0000, 0);
        add_row(ACT_SET,    0,         0, 0,                   0, 0, 3'b100, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_CTRL, 0, ctrl_word(1, 0, 0), 20, 0, 3'b000, 1, 4'b0000, 0);
        add_row(ACT_INJECT, KIND_ACK,  0, ctrl_word(0, 0, 0),  0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_INJECT, KIND_CTRL, 0, ctrl_word(1, 0, 0),  0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_ACK,  0, ctrl_word(0, 0, 0), 20, 0, 3'b000, 1, 4'b1010, 0);
        // Update out, peer update in
        add_row(ACT_SET,    0,         0, upd1,                0, 0, 3'b110, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_DATA, 1, upd1,               20, 0, 3'b000, 1, 4'b1010, 0);
        add_row(ACT_INJECT, KIND_ACK,  1, ctrl_word(0, 0, 1),  0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_INJECT, KIND_DATA, 1, peer,                0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_ACK,  1, ctrl_word(0, 0, 1), 20, 0, 3'b000, 1, 4'b1010,
                peer[15:8]);
        // Duplicate with other payload
        add_row(ACT_INJECT, KIND_DATA, 1, ~peer,               0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_ACK,  1, ctrl_word(0, 0, 1), 20, 0, 3'b000, 1, 4'b1010,
                peer[15:8]);
        // Unacknowledged update is resent
        add_row(ACT_SET,    0,         0, upd2,                0, 0, 3'b110, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_DATA, 0, upd2,               20, 0, 3'b000, 1, 4'b1010,
                peer[15:8]);
        add_row(ACT_QUIET,  0,         0, 0,                  40, 0, 3'b000, 1, 4'b1010,
                peer[15:8]);
        add_row(ACT_WAIT,   KIND_DATA, 0, upd2,               20, 1, 3'b000, 1, 4'b1010,
                peer[15:8]);
        add_row(ACT_INJECT, KIND_ACK,  0, ctrl_word(0, 0, 0),  0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_SET,    0,         0, upd2,                0, 0, 3'b101, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_CTRL, 1, ctrl_word(1, 1, 0), 20, 0, 3'b000, 1, 4'b0110,
                peer[15:8]);
        // Second run ends by the peer losing
        add_row(ACT_RESET,  0,         0, 0,                   0, 0, 3'b000, 1, 4'b0000, 0);
        add_row(ACT_SET,    0,         0, 0,                   0, 0, 3'b100, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_CTRL, 0, ctrl_word(1, 0, 0), 20, 0, 3'b000, 1, 4'b0000, 0);
        add_row(ACT_INJECT, KIND_ACK,  0, ctrl_word(0, 0, 0),  0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_INJECT, KIND_CTRL, 0, ctrl_word(1, 0, 0),  0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_ACK,  0, ctrl_word(0, 0, 0), 20, 0, 3'b000, 1, 4'b1010, 0);
        add_row(ACT_INJECT, KIND_CTRL, 1, ctrl_word(1, 1, 0),  0, 0, 3'b000, 0, 4'b0000, 0);
        add_row(ACT_WAIT,   KIND_ACK,  1, ctrl_word(0, 0, 1), 20, 0, 3'b000, 1, 4'b0011, 0);
    endtask

    // ********************
    // Main sequence
    // ********************
    initial begin
        row_t        r;
        logic [1:0]  kind;
        logic        seq;
        logic [15:0] payload;
        int          total;
        clk = 1'b0;
        build_table();
        total = 200;
        foreach (rows[i]) begin
            total += rows[i].count + 8;  // Covers frame, pulse and check cycles
            if (rows[i].retry)
                total += RETRY_CYCLES;
        end
        cycle_limit = total;
        apply_reset();
        foreach (rows[i]) begin
            r = rows[i];
            case (r.act)
                ACT_SET:    apply_inputs(r);
                ACT_INJECT: inject_frame(r.kind, r.seq, r.payload);
                ACT_RESET: begin
                    @(posedge clk);
                    #2;
                    apply_reset();
                end
                ACT_QUIET: begin
                    repeat (r.count) begin
                        @(negedge clk);
                        check_val("serial_out_h", serial_out_h, 1'b0);
                        check_val("serial_out", serial_out, '0);
                    end
                end
                default: begin
                    capture_frame(r.count + (r.retry ? RETRY_CYCLES : 0), kind, seq, payload);
                    check_val("serial_out kind", kind, r.kind);
                    check_val("serial_out seq", seq, r.seq);
                    check_val("serial_out payload", payload, r.payload);
                end
            endcase
            if (r.chk) begin
                @(negedge clk);
                check_val("game_active", game_active, r.lvl[3]);
                check_val("game_lost", game_lost, r.lvl[2]);
                check_val("opponent_ready", opponent_ready, r.lvl[1]);
                check_val("opponent_lost", opponent_lost, r.lvl[0]);
                check_val("opponent_garbage", opponent_garbage, r.opp[7:4]);
                check_val("opponent_hold", opponent_hold, r.opp[3:0]);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule : link_tb

/* link.f */
design/game_pkg.sv
design/network_pkg.sv
design/session_fsm.sv
design/packet_arbiter.sv
design/lane_serializer.sv
design/lane_deserializer.sv
design/link_top.sv
verification/link_assert.sv
verification/link_tb.sv
